/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dcacheTop
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the simulator is the result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
+incdir+source
source/cachePkg.sv
source/memBusPkg.sv
source/dataSram.sv
source/dcacheTagStore.sv
source/dcacheCtrl.sv
source/dcacheTop.sv
verification/tbMemModel.sv
verification/dcache_sva.sv
verification/tb_dcacheTop.sv

/* source/cachePkg.sv */
`include "dcache_defines.svh"

package cachePkg;

  typedef enum logic {
    opLoad  = 1'b0,
    opStore = 1'b1
  } memOp_e;

  // controller states
  typedef enum logic [2:0] {
    stIdle      = 3'd0,
    stCompare   = 3'd1,
    stWriteBack = 3'd2,
    stMiss      = 3'd3,
    stRefill    = 3'd4,
    stReplace   = 3'd5
  } cacheState_e;

  // request from the load/store stage
  typedef struct packed {
    memOp_e                     op;
    logic [`ADDR_WIDTH-1:0]     addr;
    logic [`XLEN-1:0]           wrData;
    logic [`BYTES_PER_WORD-1:0] byteMask;
  } cacheReq_t;

  // tag store answer for the latched index
  typedef struct packed {
    logic                  hitWay0;
    logic                  hitWay1;
    logic                  victimWay;
    logic                  victimDirty;
    logic [`TAG_WIDTH-1:0] victimTag;
  } tagLookup_t;

endpackage

/* source/dataSram.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

// one way of data, stands in for the two 128-bit macros of the real array
module dataSram (
  input  logic                    clk,
  input  logic                    en_i,
  input  logic                    wrEn_i,
  input  logic [`INDEX_WIDTH-1:0] index_i,
  input  logic [`LINE_WIDTH-1:0]  wrLine_i,
  input  logic [`LINE_WIDTH-1:0]  wrMask_i,
  output logic [`LINE_WIDTH-1:0]  rdLine_o
);

  logic [`LINE_WIDTH-1:0] mem [`SET_COUNT];
  logic [`LINE_WIDTH-1:0] oldLine;
  logic [`LINE_WIDTH-1:0] newLine;

  assign oldLine = mem[index_i];

  // bit mask merge, unmasked bits keep the stored value
  assign newLine = (oldLine & ~wrMask_i) | (wrLine_i & wrMask_i);

  always_ff @(posedge clk) begin
    if (en_i && wrEn_i) begin
      mem[index_i] <= newLine;
    end
  end

  // read is registered and gives the contents before the write
  // output holds while the array is not selected
  always_ff @(posedge clk) begin
    if (en_i) begin
      rdLine_o <= oldLine;
    end
  end

endmodule

/* source/dcacheCtrl.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  // processor side
  input  logic                    valid_i,
  input  logic                    stall_n,
  input  cachePkg::cacheReq_t     req_i,
  output logic                    addrOk_o,
  output logic                    dataOk_o,
  output logic                    dataNotOk_o,
  output logic [`XLEN-1:0]        rdData_o,
  // tag store
  input  cachePkg::tagLookup_t    lookup_i,
  output logic                    fillStrobe_o,
  output logic                    dirtyStrobe_o,
  output logic                    hitWay_o,
  output logic                    victimWay_o,
  output logic [`INDEX_WIDTH-1:0] index_o,
  output logic [`TAG_WIDTH-1:0]   tag_o,
  // data ways
  input  logic [`LINE_WIDTH-1:0]  way0Rd_i,
  input  logic [`LINE_WIDTH-1:0]  way1Rd_i,
  output logic [1:0]              wayEn_o,
  output logic [1:0]              wayWrEn_o,
  output logic [`INDEX_WIDTH-1:0] wayIndex_o,
  output logic [`LINE_WIDTH-1:0]  wrLine_o,
  output logic [`LINE_WIDTH-1:0]  wrMask_o,
  // memory port
  output logic                    rdValid_o,
  output memBusPkg::lineRdReq_t   rdReq_o,
  input  logic                    rdReady_i,
  input  logic                    beatValid_i,
  input  memBusPkg::memBeat_t     beat_i,
  output logic                    wrValid_o,
  output memBusPkg::lineWrReq_t   wrReq_o,
  input  logic                    wrReady_i
);

  import cachePkg::*;

  cacheState_e                curState;
  cacheState_e                nextState;
  cacheReq_t                  reqLatch;
  logic                       accept;
  logic                       hit;
  logic                       isStore;
  logic                       storeWrite;
  logic                       fromBuf;
  logic [`INDEX_WIDTH-1:0]    index;
  logic [`TAG_WIDTH-1:0]      tag;
  logic [`WORD_SEL_WIDTH-1:0] wordSel;
  logic [`WORD_SEL_WIDTH-1:0] beatCnt;
  logic [7:0]                 lfsr;
  logic [`XLEN-1:0]           byteBits;
  logic [`XLEN-1:0]           mergedBeat;
  logic [`LINE_WIDTH-1:0]     refillBuf;
  logic [`LINE_WIDTH-1:0]     hitLine;
  logic [`LINE_WIDTH-1:0]     srcLine;
  logic [`LINE_WIDTH-1:0]     victimLine;

  assign index   = reqLatch.addr[`INDEX_MSB:`INDEX_LSB];
  assign tag     = reqLatch.addr[`TAG_MSB:`TAG_LSB];
  assign wordSel = reqLatch.addr[`WORD_SEL_LSB +: `WORD_SEL_WIDTH];
  assign isStore = (reqLatch.op == opStore);
  assign hit     = lookup_i.hitWay0 | lookup_i.hitWay1;

  // handshake with the pipeline
  assign dataOk_o    = (curState == stCompare) && hit;
  assign dataNotOk_o = (curState != stIdle) && !dataOk_o;
  // a store hit owns the data array this cycle, so no new address
  assign storeWrite  = dataOk_o && isStore && !fromBuf;
  assign addrOk_o    = (curState == stIdle) || (dataOk_o && !storeWrite);
  assign accept      = valid_i && addrOk_o && stall_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= stIdle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    unique case (curState)
      stIdle: begin
        if (accept) begin
          nextState = stCompare;
        end
      end
      stCompare: begin
        if (hit) begin
          nextState = accept ? stCompare : stIdle;
        end else if (lookup_i.victimDirty) begin
          nextState = stWriteBack;
        end else begin
          nextState = stMiss;
        end
      end
      stWriteBack: begin
        if (wrReady_i) begin
          nextState = stMiss;
        end
      end
      stMiss: begin
        if (rdReady_i) begin
          nextState = stRefill;
        end
      end
      stRefill: begin
        if (beatValid_i && beat_i.last) begin
          nextState = stReplace;
        end
      end
      stReplace: nextState = stCompare;
      default:   nextState = stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= req_i;
    end
  end

  // array write in stReplace returns stale data, next compare reads the buffer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fromBuf <= 1'b0;
    end else begin
      fromBuf <= (curState == stReplace);
    end
  end

  // victim choice, x^8+x^6+x^5+x^4+1, one step per miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= 8'hA5;
    end else if (curState == stReplace) begin
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end
  end

  // byte mask widened to bits
  always_comb begin
    for (int i = 0; i < `BYTES_PER_WORD; i++) begin
      byteBits[i*8 +: 8] = {8{reqLatch.byteMask[i]}};
    end
  end

  // store miss data goes into the matching beat on its way in
  assign mergedBeat = (isStore && beatCnt == wordSel)
                    ? (beat_i.data & ~byteBits) | (reqLatch.wrData & byteBits)
                    : beat_i.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (curState == stRefill && beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (curState == stRefill && beatValid_i) begin
      refillBuf[beatCnt*`XLEN +: `XLEN] <= mergedBeat;
    end
  end

  // load data
  assign hitLine  = lookup_i.hitWay1 ? way1Rd_i : way0Rd_i;
  assign srcLine  = fromBuf ? refillBuf : hitLine;
  assign rdData_o = srcLine[wordSel*`XLEN +: `XLEN];

  // tag store control
  assign fillStrobe_o  = (curState == stReplace);
  assign dirtyStrobe_o = dataOk_o && isStore;
  assign hitWay_o      = lookup_i.hitWay1;
  assign victimWay_o   = lfsr[0];
  assign index_o       = index;
  assign tag_o         = tag;

  // data array control
  always_comb begin
    wayWrEn_o = 2'b00;
    if (curState == stReplace) begin
      wayWrEn_o = victimWay_o ? 2'b10 : 2'b01;
    end else if (storeWrite) begin
      wayWrEn_o = lookup_i.hitWay1 ? 2'b10 : 2'b01;
    end
  end

  assign wayEn_o    = wayWrEn_o | {2{accept}};
  assign wayIndex_o = accept ? req_i.addr[`INDEX_MSB:`INDEX_LSB] : index;
  assign wrLine_o   = (curState == stReplace) ? refillBuf
                                              : {`BEATS_PER_LINE{reqLatch.wrData}};
  assign wrMask_o   = (curState == stReplace)
                    ? {`LINE_WIDTH{1'b1}}
                    : ({{(`LINE_WIDTH-`XLEN){1'b0}}, byteBits} << (wordSel * `XLEN));

  // memory port, victim line is still held on the idle array outputs
  assign victimLine   = lookup_i.victimWay ? way1Rd_i : way0Rd_i;
  assign rdValid_o    = (curState == stMiss);
  assign rdReq_o.addr = {tag, index, {`OFFSET_WIDTH{1'b0}}};
  assign wrValid_o    = (curState == stWriteBack);
  assign wrReq_o.addr = {lookup_i.victimTag, index, {`OFFSET_WIDTH{1'b0}}};
  assign wrReq_o.data = victimLine;

endmodule

/* source/dcacheTagStore.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcacheTagStore (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [`INDEX_WIDTH-1:0] index_i,
  input  logic [`TAG_WIDTH-1:0]   tag_i,
  input  logic                    victimWay_i,
  input  logic                    fillStrobe_i,
  input  logic                    dirtyStrobe_i,
  input  logic                    hitWay_i,
  output cachePkg::tagLookup_t    lookup_o
);

  // way is the first array dimension
  logic [`TAG_WIDTH-1:0] tagArr [2][`SET_COUNT];
  logic [`SET_COUNT-1:0] validBits [2];
  logic [`SET_COUNT-1:0] dirtyBits [2];
  logic [1:0]            wayHit;

  // tags are only written on a line fill
  always_ff @(posedge clk) begin
    if (fillStrobe_i) begin
      tagArr[victimWay_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits[0] <= '0;
      validBits[1] <= '0;
      dirtyBits[0] <= '0;
      dirtyBits[1] <= '0;
    end else if (fillStrobe_i) begin
      // fresh line from memory is clean
      validBits[victimWay_i][index_i] <= 1'b1;
      dirtyBits[victimWay_i][index_i] <= 1'b0;
    end else if (dirtyStrobe_i) begin
      dirtyBits[hitWay_i][index_i] <= 1'b1;
    end
  end

  // compare both ways against the latched tag
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validBits[w][index_i] && (tagArr[w][index_i] == tag_i);
    end
  end

  assign lookup_o.hitWay0     = wayHit[0];
  assign lookup_o.hitWay1     = wayHit[1];
  assign lookup_o.victimWay   = victimWay_i;
  // dirty implies valid, both cleared at reset
  assign lookup_o.victimDirty = dirtyBits[victimWay_i][index_i];
  // stored tag of the victim forms the writeback address
  assign lookup_o.victimTag   = tagArr[victimWay_i][index_i];

endmodule

/* source/dcacheTop.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

module dcacheTop (
  input  logic                  clk,
  input  logic                  rst_n,
  // processor side
  input  logic                  valid_i,
  input  logic                  stall_n,
  input  cachePkg::cacheReq_t   req_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  dataNotOk_o,
  output logic [`XLEN-1:0]      rdData_o,
  // memory side
  output logic                  rdValid_o,
  output memBusPkg::lineRdReq_t rdReq_o,
  input  logic                  rdReady_i,
  input  logic                  beatValid_i,
  input  memBusPkg::memBeat_t   beat_i,
  output logic                  wrValid_o,
  output memBusPkg::lineWrReq_t wrReq_o,
  input  logic                  wrReady_i
);

  import cachePkg::*;

  tagLookup_t              lookup;
  logic                    fillStrobe;
  logic                    dirtyStrobe;
  logic                    hitWay;
  logic                    victimWay;
  logic [`INDEX_WIDTH-1:0] index;
  logic [`TAG_WIDTH-1:0]   tag;
  logic [`LINE_WIDTH-1:0]  way0Rd;
  logic [`LINE_WIDTH-1:0]  way1Rd;
  logic [1:0]              wayEn;
  logic [1:0]              wayWrEn;
  logic [`INDEX_WIDTH-1:0] wayIndex;
  logic [`LINE_WIDTH-1:0]  wrLine;
  logic [`LINE_WIDTH-1:0]  wrMask;

  dcacheCtrl i_dcacheCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .valid_i       (valid_i),
    .stall_n       (stall_n),
    .req_i         (req_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .dataNotOk_o   (dataNotOk_o),
    .rdData_o      (rdData_o),
    .lookup_i      (lookup),
    .fillStrobe_o  (fillStrobe),
    .dirtyStrobe_o (dirtyStrobe),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay),
    .index_o       (index),
    .tag_o         (tag),
    .way0Rd_i      (way0Rd),
    .way1Rd_i      (way1Rd),
    .wayEn_o       (wayEn),
    .wayWrEn_o     (wayWrEn),
    .wayIndex_o    (wayIndex),
    .wrLine_o      (wrLine),
    .wrMask_o      (wrMask),
    .rdValid_o     (rdValid_o),
    .rdReq_o       (rdReq_o),
    .rdReady_i     (rdReady_i),
    .beatValid_i   (beatValid_i),
    .beat_i        (beat_i),
    .wrValid_o     (wrValid_o),
    .wrReq_o       (wrReq_o),
    .wrReady_i     (wrReady_i)
  );

  dcacheTagStore i_dcacheTagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (index),
    .tag_i         (tag),
    .victimWay_i   (victimWay),
    .fillStrobe_i  (fillStrobe),
    .dirtyStrobe_i (dirtyStrobe),
    .hitWay_i      (hitWay),
    .lookup_o      (lookup)
  );

  dataSram way0 (
    .clk      (clk),
    .en_i     (wayEn[0]),
    .wrEn_i   (wayWrEn[0]),
    .index_i  (wayIndex),
    .wrLine_i (wrLine),
    .wrMask_i (wrMask),
    .rdLine_o (way0Rd)
  );

  dataSram way1 (
    .clk      (clk),
    .en_i     (wayEn[1]),
    .wrEn_i   (wayWrEn[1]),
    .index_i  (wayIndex),
    .wrLine_i (wrLine),
    .wrMask_i (wrMask),
    .rdLine_o (way1Rd)
  );

endmodule

/* source/dcache_defines.svh */
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// basic widths
`define ADDR_WIDTH      32
`define XLEN            64
`define SET_COUNT       64
`define LINE_WIDTH      256
`define BEATS_PER_LINE  4
`define BYTES_PER_WORD  8

// address split, offset 4..0, index 10..5, tag 31..11
`define OFFSET_WIDTH    5
`define WORD_SEL_LSB    3
`define WORD_SEL_WIDTH  $clog2(`BEATS_PER_LINE)
`define INDEX_WIDTH     6
`define INDEX_LSB       5
`define INDEX_MSB       10
`define TAG_WIDTH       21
`define TAG_LSB         11
`define TAG_MSB         (`ADDR_WIDTH - 1)

`endif

/* source/memBusPkg.sv */
`include "dcache_defines.svh"

package memBusPkg;

  // line read, address is line aligned
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;
  } lineRdReq_t;

  // full line writeback
  typedef struct packed {
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`LINE_WIDTH-1:0] data;
  } lineWrReq_t;

  // one returned beat of a line fill
  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic             last;
  } memBeat_t;

endpackage

/* verification/dcache_sva.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

// handshake rules on both sides of the cache
module dcache_sva (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  valid_i,
  input logic                  stallN_i,
  input cachePkg::cacheReq_t   req_i,
  input logic                  addrOk_i,
  input logic                  dataOk_i,
  input logic                  dataNotOk_i,
  input logic                  rdValid_i,
  input logic                  rdReady_i,
  input memBusPkg::lineRdReq_t rdReq_i,
  input logic                  wrValid_i,
  input logic                  wrReady_i,
  input memBusPkg::lineWrReq_t wrReq_i
);

  logic                               accepted;
  logic                               busy;
  logic                               lineKnown;
  logic [`ADDR_WIDTH-1:`OFFSET_WIDTH] lastLine;
  logic                               sameLine;

  assign accepted = valid_i && addrOk_i && stallN_i;
  // line of the newest request stays resident until the next lookup
  assign sameLine = lineKnown && (req_i.addr[`ADDR_WIDTH-1:`OFFSET_WIDTH] == lastLine);

  // one access is open from acceptance until its dataOk
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      lineKnown <= 1'b0;
      lastLine  <= '0;
    end else if (accepted) begin
      busy      <= 1'b1;
      lineKnown <= 1'b1;
      lastLine  <= req_i.addr[`ADDR_WIDTH-1:`OFFSET_WIDTH];
    end else if (dataOk_i) begin
      busy <= 1'b0;
    end
  end

  // memory requests stay up and steady until taken
  rdHold: assert property (@(posedge clk) disable iff (!rst_n)
    rdValid_i && !rdReady_i |=> rdValid_i && $stable(rdReq_i))
    else $error("line read request changed before the memory took it");

  wrHold: assert property (@(posedge clk) disable iff (!rst_n)
    wrValid_i && !wrReady_i |=> wrValid_i && $stable(wrReq_i))
    else $error("line write request changed before the memory took it");

  okExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    busy ? $onehot({dataOk_i, dataNotOk_i}) : !(dataOk_i || dataNotOk_i))
    else $error("dataOk and dataNotOk out of step with the open access");

  hitLatency: assert property (@(posedge clk) disable iff (!rst_n)
    accepted && sameLine |=> dataOk_i)
    else $error("hit did not complete one cycle after acceptance");

endmodule

bind dcacheTop dcache_sva i_dcacheSva (
  .clk         (clk),
  .rst_n       (rst_n),
  .valid_i     (valid_i),
  .stallN_i    (stall_n),
  .req_i       (req_i),
  .addrOk_i    (addrOk_o),
  .dataOk_i    (dataOk_o),
  .dataNotOk_i (dataNotOk_o),
  .rdValid_i   (rdValid_o),
  .rdReady_i   (rdReady_i),
  .rdReq_i     (rdReq_o),
  .wrValid_i   (wrValid_o),
  .wrReady_i   (wrReady_i),
  .wrReq_i     (wrReq_o)
);

/* verification/tbMemModel.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

// burst memory behind the cache, serves one line request at a time
module tbMemModel (
  input  logic                  clk,
  input  logic                  stallEn_i,
  input  logic                  rdValid_i,
  input  memBusPkg::lineRdReq_t rdReq_i,
  output logic                  rdReady_o,
  output logic                  beatValid_o,
  output memBusPkg::memBeat_t   beat_o,
  input  logic                  wrValid_i,
  input  memBusPkg::lineWrReq_t wrReq_i,
  output logic                  wrReady_o
);

  import memBusPkg::*;

  localparam int memWords = 2048;

  logic [`XLEN-1:0]       shadow [memWords];
  logic                   rdTaken;
  logic                   wrTaken;
  logic                   stallNow;
  logic [`ADDR_WIDTH-1:0] rdAddr;
  lineWrReq_t             wrHeld;
  logic [10:0]            wordIdx;
  int                     beatsLeft;

  // initial contents depend on every address bit
  function automatic logic [`XLEN-1:0] initHash(input logic [`ADDR_WIDTH-1:0] addr);
    return {addr ^ 32'h9e3779b9, (addr * 32'h85ebca6b) ^ 32'hc2b2ae35};
  endfunction

  initial begin
    for (int i = 0; i < memWords; i++) begin
      shadow[i] = initHash(32'(i * 8));
    end
    rdReady_o   = 1'b0;
    wrReady_o   = 1'b0;
    beatValid_o = 1'b0;
    beat_o      = '0;
    rdTaken     = 1'b0;
    wrTaken     = 1'b0;
    rdAddr      = '0;
    wrHeld      = '0;
    beatsLeft   = 0;
    forever begin
      @(posedge clk);
      stallNow = stallEn_i;
      #2;
      // handshakes completed at the edge just passed
      if (wrTaken) begin
        for (int b = 0; b < `BEATS_PER_LINE; b++) begin
          wordIdx = wrHeld.addr[13:3] + 11'(b);
          shadow[wordIdx] = wrHeld.data[b*`XLEN +: `XLEN];
        end
      end
      if (rdTaken) begin
        beatsLeft = `BEATS_PER_LINE;
      end
      if (beatsLeft > 0) begin
        wordIdx     = rdAddr[13:3] + 11'(`BEATS_PER_LINE - beatsLeft);
        beatValid_o = 1'b1;
        beat_o.data = shadow[wordIdx];
        beat_o.last = (beatsLeft == 1);
        beatsLeft--;
      end else begin
        beatValid_o = 1'b0;
        beat_o.last = 1'b0;
      end
      // ready drops about one cycle in four when stalls are on
      rdReady_o = !stallNow || ($urandom_range(3) != 0);
      wrReady_o = !stallNow || ($urandom_range(3) != 0);
      rdTaken   = rdValid_i && rdReady_o;
      wrTaken   = wrValid_i && wrReady_o;
      rdAddr    = rdReq_i.addr;
      wrHeld    = wrReq_i;
    end
  end

endmodule

/* verification/tb_dcacheTop.sv */
`timescale 1ns/10ps
`include "dcache_defines.svh"

module tb_dcacheTop;

  import cachePkg::*;
  import memBusPkg::*;

  localparam int memBytes     = 16384;
  localparam int randomRows   = 200;
  localparam int cyclesPerRow = 40;

  logic             clk;
  logic             rst_n;
  logic             valid;
  logic             stallN;
  cacheReq_t        req;
  logic             addrOk;
  logic             dataOk;
  logic             dataNotOk;
  logic [`XLEN-1:0] rdData;
  logic             rdValid;
  lineRdReq_t       rdReq;
  logic             rdReady;
  logic             beatValid;
  memBeat_t         beat;
  logic             wrValid;
  lineWrReq_t       wrReq;
  logic             wrReady;
  logic             memStall;

  // stimulus table, one request per row
  cacheReq_t rowReq[$];
  string     rowName[$];
  int        pending[$];
  int        firstRandomRow;
  int        wbCount;
  logic [7:0] golden [memBytes];

  dcacheTop i_dcacheTop (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid_i     (valid),
    .stall_n     (stallN),
    .req_i       (req),
    .addrOk_o    (addrOk),
    .dataOk_o    (dataOk),
    .dataNotOk_o (dataNotOk),
    .rdData_o    (rdData),
    .rdValid_o   (rdValid),
    .rdReq_o     (rdReq),
    .rdReady_i   (rdReady),
    .beatValid_i (beatValid),
    .beat_i      (beat),
    .wrValid_o   (wrValid),
    .wrReq_o     (wrReq),
    .wrReady_i   (wrReady)
  );

  tbMemModel i_memModel (
    .clk         (clk),
    .stallEn_i   (memStall),
    .rdValid_i   (rdValid),
    .rdReq_i     (rdReq),
    .rdReady_o   (rdReady),
    .beatValid_o (beatValid),
    .beat_o      (beat),
    .wrValid_i   (wrValid),
    .wrReq_i     (wrReq),
    .wrReady_o   (wrReady)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic checkValue(input string testName, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic addRow(input memOp_e op, input logic [`ADDR_WIDTH-1:0] addr,
                        input logic [`XLEN-1:0] data, input logic [7:0] mask,
                        input string name);
    cacheReq_t row;
    row.op       = op;
    row.addr     = addr;
    row.wrData   = data;
    row.byteMask = mask;
    rowReq.push_back(row);
    rowName.push_back(name);
  endtask

  function automatic logic [`XLEN-1:0] goldenWord(input logic [`ADDR_WIDTH-1:0] addr);
    logic [`XLEN-1:0] word;
    int base;
    base = int'(addr[13:3]) * 8;
    for (int b = 0; b < 8; b++) begin
      word[b*8 +: 8] = golden[base + b];
    end
    return word;
  endfunction

  task automatic buildTable();
    logic [`ADDR_WIDTH-1:0] addr;
    // cold miss, then hits on the same line
    addRow(opLoad, 32'h100, '0, 8'h00, "coldLoadMiss");
    addRow(opLoad, 32'h108, '0, 8'h00, "lineHit");
    addRow(opLoad, 32'h110, '0, 8'h00, "lineHit");
    addRow(opLoad, 32'h118, '0, 8'h00, "lineHit");
    addRow(opLoad, 32'h100, '0, 8'h00, "lineHit");
    // partial masks on a resident line
    addRow(opStore, 32'h108, 64'h1122334455667788, 8'h0F, "storeMergeLow");
    addRow(opStore, 32'h108, 64'hA1B2C3D4E5F60718, 8'hA0, "storeMergeHigh");
    addRow(opLoad, 32'h108, '0, 8'h00, "storeMergeLoad");
    addRow(opStore, 32'h118, 64'hFFEEDDCCBBAA9988, 8'h81, "storeMergeEdge");
    addRow(opLoad, 32'h118, '0, 8'h00, "storeMergeLoad");
    // lines 0x100, 0x900 and 0x1100 share set 8
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 3; k++) begin
        addr = 32'h100 + 32'(k) * 32'h800 + 32'(r * 8);
        addRow(opStore, addr, {16'(k), 16'(r), 32'h3c5a96e1},
               (r == 1) ? 8'h3C : 8'hFF, "evictStore");
      end
    end
    for (int k = 0; k < 3; k++) begin
      for (int r = 0; r < 3; r++) begin
        addRow(opLoad, 32'h100 + 32'(k) * 32'h800 + 32'(r * 8), '0, 8'h00, "evictLoad");
      end
    end
    firstRandomRow = rowReq.size();
    for (int i = 0; i < randomRows; i++) begin
      addr = 32'($urandom_range(511)) << 3;
      if ($urandom_range(1) == 1) begin
        addRow(opStore, addr, {$urandom, $urandom}, 8'($urandom_range(255, 1)), "randomMix");
      end else begin
        addRow(opLoad, addr, '0, 8'h00, "randomMix");
      end
    end
  endtask

  // loads check against the golden bytes, stores update them
  task automatic completeRow(input int idx);
    cacheReq_t row;
    int base;
    row  = rowReq[idx];
    base = int'(row.addr[13:3]) * 8;
    if (row.op == opLoad) begin
      checkValue(rowName[idx], goldenWord(row.addr), rdData);
    end else begin
      for (int b = 0; b < 8; b++) begin
        if (row.byteMask[b]) begin
          golden[base + b] = row.wrData[b*8 +: 8];
        end
      end
    end
  endtask

  task automatic checkWriteback();
    for (int b = 0; b < `BEATS_PER_LINE; b++) begin
      checkValue("writebackData", goldenWord(wrReq.addr + 32'(b * 8)),
                 wrReq.data[b*`XLEN +: `XLEN]);
    end
  endtask

  // resident lines are newer than memory
  task automatic checkImage();
    logic [`ADDR_WIDTH-1:0]  addr;
    logic [`INDEX_WIDTH-1:0] idx;
    logic [`TAG_WIDTH-1:0]   tag;
    logic [`LINE_WIDTH-1:0]  line;
    logic [`XLEN-1:0]        actual;
    for (int w = 0; w < memBytes / 8; w++) begin
      addr   = 32'(w * 8);
      idx    = addr[`INDEX_MSB:`INDEX_LSB];
      tag    = addr[`TAG_MSB:`TAG_LSB];
      actual = i_memModel.shadow[w];
      if (i_dcacheTop.i_dcacheTagStore.validBits[0][idx] &&
          i_dcacheTop.i_dcacheTagStore.tagArr[0][idx] == tag) begin
        line   = i_dcacheTop.way0.mem[idx];
        actual = line[addr[4:3]*`XLEN +: `XLEN];
      end else if (i_dcacheTop.i_dcacheTagStore.validBits[1][idx] &&
                   i_dcacheTop.i_dcacheTagStore.tagArr[1][idx] == tag) begin
        line   = i_dcacheTop.way1.mem[idx];
        actual = line[addr[4:3]*`XLEN +: `XLEN];
      end
      checkValue("finalImage", goldenWord(addr), actual);
    end
  endtask

  // writebacks and line reads are sampled mid cycle
  initial begin
    wbCount = 0;
    forever begin
      @(negedge clk);
      if (rst_n && wrValid && wrReady) begin
        wbCount++;
        checkWriteback();
      end
      if (rst_n && rdValid && rdReady) begin
        checkValue("lineReadBusy", 64'(1), 64'(pending.size() > 0));
        checkValue("lineReadAddr", 64'(rowReq[pending[0]].addr & ~32'h1f),
                   64'(rdReq.addr));
      end
    end
  end

  initial begin
    int   rowIdx;
    int   cycles;
    int   limit;
    int   doneIdx;
    logic acceptNext;
    void'($urandom(32'h6e08d8c3));
    rst_n    = 1'b0;
    valid    = 1'b0;
    stallN   = 1'b1;
    req      = '0;
    memStall = 1'b0;
    buildTable();
    limit = rowReq.size() * cyclesPerRow;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    for (int i = 0; i < memBytes; i++) begin
      golden[i] = i_memModel.shadow[i / 8][(i % 8) * 8 +: 8];
    end
    rowIdx     = 0;
    cycles     = 0;
    acceptNext = 1'b0;
    while (rowIdx < rowReq.size() || pending.size() > 0) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > limit) begin
        $display("timeout after %0d cycles, %0d of %0d rows issued, %0d pending",
                 cycles, rowIdx, rowReq.size(), pending.size());
        $display("TB FAILED");
        $fatal(1, "simulation timeout");
      end
      if (acceptNext) begin
        pending.push_back(rowIdx);
        // a line touched by the previous access must hit at once
        if (rowName[rowIdx] == "lineHit") begin
          checkValue("lineHitLatency", 64'(1), 64'(dataOk));
        end
        rowIdx++;
      end
      checkValue("dataNotOk", 64'(pending.size() > 0 && !dataOk), 64'(dataNotOk));
      // no new address while an access is still open
      if (!dataOk) begin
        checkValue("addrOk", 64'(pending.size() == 0), 64'(addrOk));
      end
      if (dataOk) begin
        checkValue("dataOkWhileIdle", 64'(0), 64'(pending.size() == 0));
        doneIdx = pending.pop_front();
        completeRow(doneIdx);
      end
      if (rowIdx < rowReq.size()) begin
        valid    = 1'b1;
        req      = rowReq[rowIdx];
        memStall = (rowIdx >= firstRandomRow);
        stallN   = (rowIdx < firstRandomRow) || ($urandom_range(7) != 0);
      end else begin
        valid  = 1'b0;
        stallN = 1'b1;
      end
      acceptNext = valid && addrOk && stallN;
    end
    // let the last store reach the array
    repeat (2) @(posedge clk);
    checkImage();
    checkValue("evictWriteback", 64'(1), 64'(wbCount > 0));
    $display("TB PASSED");
    $finish;
  end

endmodule
